/* src.f */
common/rv_pkg.sv
common/decode_if.sv
rtl/rv_alu.sv
rtl/rv_regfile.sv
rtl/rv_memory.sv
rtl/rv_decoder.sv
rtl/rv_core_top.sv
dv/tb_clock.sv
dv/rv_core_tb.sv

/* Makefile */
# Verilator flow for the rv64i core testbench
# usage: make sim, make clean, or override e.g. make sim TOP=rv_core_tb LOG=run.log

VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= All tests passed!

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/program_input.txt */
# P <instr hex> [mnemonic]   program word, stored from the reset pc upward
# E <pc> <rd> <wdata>   expected commit;  H <halted> <illegal> <pc>   end of a program
# program 1: alu, word forms, lui/auipc, x0, stores, loads, jal, jalr, ebreak
P 123450b7 lui
P 67808093 addi
P fff00113 addi
P 02409193 slli
P 40100233 sub
P 40425293 srai
P 03c25313 srli
P 001223b3 slt
P 00123433 sltu
P 0040c4b3 xor
P 0ff0f513 andi
P 006565b3 or
P 0052863b addw
P 7ff0869b addiw
P 00001717 auipc
P 00508013 addi_x0
P 10000793 addi
P 0047b023 sd
P 001780a3 sb
P 00179123 sh
P 0017a423 sw
P 00178803 lb
P 00078883 lb
P 0007c903 lbu
P 00679983 lh
P 0067da03 lhu
P 0047aa83 lw
P 0047eb03 lwu
P 0087ab83 lw
P 0007bc03 ld
P 00800cef jal
P 00100073 ebreak_skipped
P 00000d97 auipc
P 00dd8d67 jalr
P 00100073 ebreak_skipped
P 001d0e13 addi
P 00100073 ebreak
E 80000000 01 0000000012345000
E 80000004 01 0000000012345678
E 80000008 02 ffffffffffffffff
E 8000000c 03 2345678000000000
E 80000010 04 ffffffffedcba988
E 80000014 05 fffffffffedcba98
E 80000018 06 000000000000000f
E 8000001c 07 0000000000000001
E 80000020 08 0000000000000000
E 80000024 09 fffffffffffffff0
E 80000028 0a 0000000000000078
E 8000002c 0b 000000000000007f
E 80000030 0c fffffffffdb97530
E 80000034 0d 0000000012345e77
E 80000038 0e 0000000080001038
E 8000003c 00 0000000000000000
E 80000040 0f 0000000000000100
E 80000044 00 0000000000000000
E 80000048 00 0000000000000000
E 8000004c 00 0000000000000000
E 80000050 00 0000000000000000
E 80000054 10 0000000000000078
E 80000058 11 ffffffffffffff88
E 8000005c 12 0000000000000088
E 80000060 13 ffffffffffffffff
E 80000064 14 000000000000ffff
E 80000068 15 ffffffffffffffff
E 8000006c 16 00000000ffffffff
E 80000070 17 0000000012345678
E 80000074 18 ffffffff56787888
E 80000078 19 000000008000007c
E 80000080 1b 0000000080000080
E 80000084 1a 0000000080000088
E 8000008c 1c 0000000080000089
H 1 0 80000090
# program 2: one addi, then an undefined opcode
P 12300293 addi
P 0000000b undefined
E 80000000 05 0000000000000123
H 0 1 80000004

/* dv/rv_core_tb.sv */
////////////////////
// testbench for the single-cycle rv64i core
// reads programs and expected commit traces from dv/program_input.txt
// each program: reset, load with run low, run with random idle gaps
// every commit is checked against the trace, then the final flags
////////////////////
`timescale 1ns/10ps
`default_nettype none

module rv_core_tb;

  localparam int IMEM_AW = 10;
  localparam int DMEM_AW = 10;

  logic                clk;
  logic                reset;
  logic                run;
  logic                prog_wen;
  logic [IMEM_AW-1:0]  prog_addr;
  rv_pkg::inst_t       prog_data;
  rv_pkg::xlen_t       pc;
  logic                commit;
  rv_pkg::reg_id_t     commit_rd;
  rv_pkg::xlen_t       commit_wdata;
  logic                halted;
  logic                illegal;

  // whole data file, consumed section by section
  logic [31:0] prog_q [$];
  logic [63:0] exp_pc_q [$];
  logic [63:0] exp_rd_q [$];
  logic [63:0] exp_wd_q [$];
  int          sec_prog_n [$];
  int          sec_trace_n [$];
  logic [63:0] sec_pc [$];
  logic        sec_halt [$];
  logic        sec_ill [$];

  int          cycles = 0;
  int          cycle_limit = 100000;
  int unsigned seed_val;

  tb_clock #(.PERIOD_NS(100)) tb_clock_i (.clk(clk));

  rv_core_top #(
    .IMEM_AW (IMEM_AW),
    .DMEM_AW (DMEM_AW)
  ) rv_core_top_i (
    .clk          (clk),
    .reset        (reset),
    .run          (run),
    .prog_wen     (prog_wen),
    .prog_addr    (prog_addr),
    .prog_data    (prog_data),
    .pc           (pc),
    .commit       (commit),
    .commit_rd    (commit_rd),
    .commit_wdata (commit_wdata),
    .halted       (halted),
    .illegal      (illegal)
  );

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s expected %h actual %h", name, expected, actual);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Test failures found");
    $fatal(1);
  endtask

  // P word, E pc rd wdata, H halted illegal pc closes a program
  task automatic read_data_file();
    string       line;
    int          n;
    int          code;
    int          n_prog;
    int          n_trace;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] c;
    n_prog  = 0;
    n_trace = 0;
    fd_open: begin
      int fd;
      fd = $fopen("dv/program_input.txt", "r");
      if (fd == 0) begin
        abort_run("could not open the data file dv/program_input.txt");
      end else begin
        while (!$feof(fd)) begin
          code = $fgets(line, fd);
          if (code == 0)
            break;
          // blank and comment lines
          if (line.len() < 2 || line[0] == "#")
            continue;
          a = '0;
          b = '0;
          c = '0;
          n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c);
          case (line[0])
            "P": begin
              if (n < 1) begin
                abort_run("program line in the data file has no word");
              end else begin
                prog_q.push_back(a[31:0]);
                n_prog++;
              end
            end
            "E": begin
              if (n != 3) begin
                abort_run("trace line in the data file needs pc, rd and wdata");
              end else begin
                exp_pc_q.push_back(a);
                exp_rd_q.push_back(b);
                exp_wd_q.push_back(c);
                n_trace++;
              end
            end
            "H": begin
              if (n != 3) begin
                abort_run("flag line in the data file needs halted, illegal and pc");
              end else begin
                sec_halt.push_back(a[0]);
                sec_ill.push_back(b[0]);
                sec_pc.push_back(c);
                sec_prog_n.push_back(n_prog);
                sec_trace_n.push_back(n_trace);
                n_prog  = 0;
                n_trace = 0;
              end
            end
            default: abort_run("unknown line type in the data file");
          endcase
        end
        $fclose(fd);
      end
    end
  endtask

  // one program: reset, load, run through its trace, check the stop
  task automatic run_section(input int n_prog, input int n_trace, input logic [63:0] fin_pc,
                             input logic fin_halt, input logic fin_ill);
    int done;
    int gap;
    done = 0;
    gap  = 0;
    @(posedge clk);
    reset    <= 1'b1;
    run      <= 1'b0;
    prog_wen <= 1'b0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    // one word per edge, run stays low
    for (int i = 0; i < n_prog; i++) begin
      prog_wen  <= 1'b1;
      prog_addr <= IMEM_AW'(i);
      prog_data <= prog_q.pop_front();
      @(posedge clk);
    end
    prog_wen <= 1'b0;
    while (done < n_trace) begin
      if (gap > 0) begin
        run <= 1'b0;
        gap--;
      end else begin
        run <= 1'b1;
        if ($urandom % 6 == 0)
          gap = 1 + int'($urandom % 3);
      end
      // outputs settled mid cycle
      @(negedge clk);
      if (!run) begin
        // idle gap, pc waits on the next instruction
        check_value("commit", 64'd0, {63'b0, commit});
        check_value("pc", exp_pc_q[0], pc);
      end else if (!commit) begin
        check_value("commit", 64'd1, {63'b0, commit});
      end else begin
        check_value("pc", exp_pc_q.pop_front(), pc);
        check_value("commit_rd", exp_rd_q.pop_front(), {59'b0, commit_rd});
        check_value("commit_wdata", exp_wd_q.pop_front(), commit_wdata);
        done++;
      end
      @(posedge clk);
    end
    // core should now sit frozen on its stopping word
    repeat (4) begin
      run <= 1'b1;
      @(negedge clk);
      check_value("commit", 64'd0, {63'b0, commit});
      check_value("pc", fin_pc, pc);
      @(posedge clk);
    end
    check_value("halted", {63'b0, fin_halt}, {63'b0, halted});
    check_value("illegal", {63'b0, fin_ill}, {63'b0, illegal});
    run <= 1'b0;
  endtask

  // run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: the core did not finish its trace in %0d cycles", cycle_limit);
      $display("Test failures found");
      $fatal(1);
    end
  end

  initial begin
    reset     <= 1'b1;
    run       <= 1'b0;
    prog_wen  <= 1'b0;
    prog_addr <= '0;
    prog_data <= '0;
    seed_val = $urandom(32'h599b4e76);
    read_data_file();
    cycle_limit = 4 * exp_pc_q.size() + prog_q.size() + 50;
    if (sec_pc.size() == 0) begin
      abort_run("the data file holds no complete program");
    end else begin
      while (sec_pc.size() > 0) begin
        run_section(sec_prog_n.pop_front(), sec_trace_n.pop_front(), sec_pc.pop_front(),
                    sec_halt.pop_front(), sec_ill.pop_front());
      end
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* dv/tb_clock.sv */
////////////////////
// free running testbench clock
// starts low, first rising edge after half a period
////////////////////
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS = 100
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  // half period high, half low
  always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire

/* rtl/rv_core_top.sv */
////////////////////
// single-cycle rv64i core top
// one instruction commits per clock while run is high
// program loaded through prog_* with run low
// ebreak sets halted, an undecodable word sets illegal
////////////////////
`timescale 1ns/10ps
`default_nettype none

module rv_core_top #(
  parameter rv_pkg::xlen_t RESET_PC = rv_pkg::reset_pc,
  parameter int            IMEM_AW  = 10,
  parameter int            DMEM_AW  = 10
) (
  input  wire logic               clk,
  input  wire logic               reset,
  input  wire logic               run,
  input  wire logic               prog_wen,
  input  wire logic [IMEM_AW-1:0] prog_addr,
  input  wire rv_pkg::inst_t      prog_data,
  output rv_pkg::xlen_t           pc,
  output logic                    commit,
  output rv_pkg::reg_id_t         commit_rd,
  output rv_pkg::xlen_t           commit_wdata,
  output logic                    halted,
  output logic                    illegal
);

  decode_if dec_if ();

  rv_pkg::inst_t instr;
  rv_pkg::xlen_t rdata_1;
  rv_pkg::xlen_t rdata_2;
  rv_pkg::xlen_t op_a;
  rv_pkg::xlen_t op_b;
  rv_pkg::xlen_t alu_result;
  rv_pkg::xlen_t load_data;
  rv_pkg::xlen_t wb_data;
  rv_pkg::xlen_t pc_plus4;
  rv_pkg::xlen_t next_pc;
  logic          step;
  logic          reg_we;
  logic          mem_we;

  // core may advance this cycle
  assign step   = run & ~halted & ~illegal;
  // ebreak and illegal words stop the core instead of committing
  assign commit = step & ~dec_if.is_ebreak & ~dec_if.is_illegal;
  assign reg_we = commit & dec_if.reg_wen;
  assign mem_we = commit & dec_if.mem_wen;

  // operand select
  assign op_a = dec_if.is_auipc ? pc : rdata_1;
  assign op_b = dec_if.need_imm ? dec_if.imm : rdata_2;

  assign pc_plus4 = pc + 64'd4;
  // jalr target with bit 0 cleared
  assign next_pc  = dec_if.is_jal  ? pc + dec_if.imm :
                    dec_if.is_jalr ? {alu_result[63:1], 1'b0} : pc_plus4;

  // write-back select, link address for jumps
  assign wb_data = (dec_if.is_jal | dec_if.is_jalr) ? pc_plus4 :
                   dec_if.is_load ? load_data : alu_result;

  // x0 writes report as no write
  assign commit_rd    = reg_we ? dec_if.rd : '0;
  assign commit_wdata = (commit_rd != '0) ? wb_data : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc      <= RESET_PC;
      halted  <= 1'b0;
      illegal <= 1'b0;
    end else begin
      if (commit)
        pc <= next_pc;
      // sticky until reset
      if (step && dec_if.is_ebreak)
        halted <= 1'b1;
      if (step && dec_if.is_illegal)
        illegal <= 1'b1;
    end
  end

  rv_memory #(
    .IMEM_AW (IMEM_AW),
    .DMEM_AW (DMEM_AW)
  ) rv_memory_i (
    .clk           (clk),
    .prog_wen      (prog_wen),
    .prog_addr     (prog_addr),
    .prog_data     (prog_data),
    .fetch_pc      (pc - RESET_PC),
    .addr          (alu_result),
    .wdata         (rdata_2),
    .wmask         (dec_if.wmask),
    .wen           (mem_we),
    .size          (dec_if.mem_size),
    .unsigned_load (dec_if.load_unsigned),
    .instr         (instr),
    .rdata         (load_data)
  );

  rv_decoder rv_decoder_i (
    .instr   (instr),
    .rs1_low (rdata_1[2:0]),
    .dec     (dec_if.dec)
  );

  rv_regfile #(
    .AW ($bits(rv_pkg::reg_id_t)),
    .DW ($bits(rv_pkg::xlen_t))
  ) rv_regfile_i (
    .clk     (clk),
    .wen     (reg_we),
    .rd      (dec_if.rd),
    .wdata   (wb_data),
    .rs1     (dec_if.rs1),
    .rs2     (dec_if.rs2),
    .rdata_1 (rdata_1),
    .rdata_2 (rdata_2)
  );

  rv_alu rv_alu_i (
    .a      (op_a),
    .b      (op_b),
    .op     (dec_if.alu_op),
    .word   (dec_if.is_word),
    .result (alu_result)
  );

  assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
    else $error("pc not word aligned");

  assert property (@(posedge clk) disable iff (reset) (halted |=> halted) and
                   (illegal |=> illegal))
    else $error("status flag dropped outside reset");

endmodule

`default_nettype wire

/* rtl/rv_decoder.sv */
////////////////////
// combinational rv64i decoder
// fields, immediates, alu code, control flags and store byte mask
// rs1_low is the live rs1 value, needed only for the store lane
////////////////////
`timescale 1ns/10ps
`default_nettype none

module rv_decoder (
  input  wire rv_pkg::inst_t instr,
  input  wire logic [2:0]    rs1_low,
  decode_if.dec              dec
);

  logic [6:0]    opcode;
  logic [2:0]    funct3;
  logic [6:0]    funct7;
  rv_pkg::xlen_t imm_i;
  rv_pkg::xlen_t imm_s;
  rv_pkg::xlen_t imm_u;
  rv_pkg::xlen_t imm_j;
  logic [2:0]    lane;

  // lane 0 mask for each access size
  function automatic rv_pkg::wmask_t size_mask(input rv_pkg::mem_size_t size);
    case (size)
      2'd0:    size_mask = 8'h01;
      2'd1:    size_mask = 8'h03;
      2'd2:    size_mask = 8'h0f;
      default: size_mask = 8'hff;
    endcase
  endfunction

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // immediate formats
  assign imm_i = {{52{instr[31]}}, instr[31:20]};
  assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};
  assign imm_j = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // byte offset of the store address inside its double word
  assign lane = rs1_low + imm_s[2:0];

  always_comb begin
    dec.rd            = instr[11:7];
    dec.rs1           = instr[19:15];
    dec.rs2           = instr[24:20];
    dec.imm           = imm_i;
    dec.alu_op        = rv_pkg::alu_add;
    dec.need_imm      = 1'b0;
    dec.is_word       = 1'b0;
    dec.is_auipc      = 1'b0;
    dec.is_jal        = 1'b0;
    dec.is_jalr       = 1'b0;
    dec.is_load       = 1'b0;
    dec.reg_wen       = 1'b0;
    dec.mem_wen       = 1'b0;
    dec.mem_size      = funct3[1:0];
    dec.load_unsigned = funct3[2];
    dec.is_ebreak     = 1'b0;
    dec.is_illegal    = 1'b0;
    case (opcode)
      rv_pkg::op_imm: begin
        dec.need_imm = 1'b1;
        dec.reg_wen  = 1'b1;
        // alt bit only means srai, elsewhere it is immediate data
        dec.alu_op   = {(funct3 == 3'b101) & instr[30], funct3};
        // 6-bit shamt leaves instr[31:26] as funct6
        if (funct3 == 3'b001 && instr[31:26] != 6'b0)
          dec.is_illegal = 1'b1;
        if (funct3 == 3'b101 && {instr[31], instr[29:26]} != 5'b0)
          dec.is_illegal = 1'b1;
      end
      rv_pkg::op_imm_32, rv_pkg::op_32: begin
        dec.need_imm = (opcode == rv_pkg::op_imm_32);
        dec.is_word  = 1'b1;
        dec.reg_wen  = 1'b1;
        dec.alu_op   = {instr[30], funct3};
        // addiw takes any immediate
        if (dec.need_imm && funct3 == 3'b000)
          dec.alu_op = rv_pkg::alu_add;
        else if (!(funct3 == 3'b001 && funct7 == 7'b0) &&
                 !(funct3 == 3'b101 && {funct7[6], funct7[4:0]} == 6'b0) &&
                 !(funct3 == 3'b000 && {funct7[6], funct7[4:0]} == 6'b0))
          dec.is_illegal = 1'b1;
      end
      rv_pkg::op: begin
        dec.reg_wen = 1'b1;
        dec.alu_op  = {funct7[5], funct3};
        // alt encoding only for sub and sra
        if ({funct7[6], funct7[4:0]} != 6'b0)
          dec.is_illegal = 1'b1;
        if (funct7[5] && funct3 != 3'b000 && funct3 != 3'b101)
          dec.is_illegal = 1'b1;
      end
      rv_pkg::lui: begin
        dec.imm      = imm_u;
        dec.need_imm = 1'b1;
        dec.reg_wen  = 1'b1;
        dec.alu_op   = rv_pkg::alu_pass_b;
      end
      rv_pkg::auipc: begin
        dec.imm      = imm_u;
        dec.need_imm = 1'b1;
        dec.is_auipc = 1'b1;
        dec.reg_wen  = 1'b1;
      end
      rv_pkg::jal: begin
        dec.imm     = imm_j;
        dec.is_jal  = 1'b1;
        dec.reg_wen = 1'b1;
      end
      rv_pkg::jalr: begin
        // target comes out of the alu as rs1 + imm
        dec.need_imm   = 1'b1;
        dec.is_jalr    = 1'b1;
        dec.reg_wen    = 1'b1;
        dec.is_illegal = (funct3 != 3'b000);
      end
      rv_pkg::load: begin
        dec.need_imm   = 1'b1;
        dec.is_load    = 1'b1;
        dec.reg_wen    = 1'b1;
        // no unsigned double load
        dec.is_illegal = (funct3 == 3'b111);
      end
      rv_pkg::store: begin
        dec.imm        = imm_s;
        dec.need_imm   = 1'b1;
        dec.mem_wen    = 1'b1;
        dec.is_illegal = funct3[2];
      end
      rv_pkg::system: begin
        dec.is_ebreak  = (instr == rv_pkg::ebreak_inst);
        dec.is_illegal = (instr != rv_pkg::ebreak_inst);
      end
      default: dec.is_illegal = 1'b1;
    endcase
    // illegal words never write anything
    if (dec.is_illegal) begin
      dec.reg_wen = 1'b0;
      dec.mem_wen = 1'b0;
    end
  end

  // mask shifted to the store lane
  assign dec.wmask = dec.mem_wen ? rv_pkg::wmask_t'(size_mask(funct3[1:0]) << lane) : '0;

  // halt and trap are exclusive causes for the top's sticky flags
  always_comb begin
    assert (!(dec.is_illegal && dec.is_ebreak))
      else $error("decoder flagged ebreak and illegal together");
  end

endmodule

`default_nettype wire

/* rtl/rv_memory.sv */
////////////////////
// instruction and data memories of the core
// imem filled through the program port, fetch index is pc - reset pc
// dmem holds double words, byte masked stores, extending loads
////////////////////
`timescale 1ns/10ps
`default_nettype none

module rv_memory #(
  parameter int IMEM_AW = 10,
  parameter int DMEM_AW = 10
) (
  input  wire logic               clk,
  input  wire logic               prog_wen,
  input  wire logic [IMEM_AW-1:0] prog_addr,
  input  wire rv_pkg::inst_t      prog_data,
  input  wire rv_pkg::xlen_t      fetch_pc,
  input  wire rv_pkg::xlen_t      addr,
  input  wire rv_pkg::xlen_t      wdata,
  input  wire rv_pkg::wmask_t     wmask,
  input  wire logic               wen,
  input  wire rv_pkg::mem_size_t  size,
  input  wire logic               unsigned_load,
  output rv_pkg::inst_t           instr,
  output rv_pkg::xlen_t           rdata
);

  rv_pkg::inst_t      imem [2**IMEM_AW];
  rv_pkg::xlen_t      dmem [2**DMEM_AW];
  logic [DMEM_AW-1:0] d_idx;
  logic [5:0]         lane_bits;
  rv_pkg::xlen_t      wdata_lane;
  rv_pkg::xlen_t      rword;

  // program load port
  always_ff @(posedge clk) begin
    if (prog_wen)
      imem[prog_addr] <= prog_data;
  end

  // word fetch, low pc bits dropped
  assign instr = imem[fetch_pc[IMEM_AW+1:2]];

  assign d_idx      = addr[DMEM_AW+2:3];
  assign lane_bits  = {addr[2:0], 3'b000};
  // store data moved up to its byte lane
  assign wdata_lane = wdata << lane_bits;

  always_ff @(posedge clk) begin
    if (wen) begin
      for (int b = 0; b < 8; b++) begin
        if (wmask[b])
          dmem[d_idx][8*b +: 8] <= wdata_lane[8*b +: 8];
      end
    end
  end

  // load lane brought down to bit 0, then extended by size
  assign rword = dmem[d_idx] >> lane_bits;

  always_comb begin
    case (size)
      2'd0:    rdata = {{56{~unsigned_load & rword[7]}}, rword[7:0]};
      2'd1:    rdata = {{48{~unsigned_load & rword[15]}}, rword[15:0]};
      2'd2:    rdata = {{32{~unsigned_load & rword[31]}}, rword[31:0]};
      default: rdata = rword;
    endcase
  end

  // decoder mask and top's store enable must agree
  assert property (@(posedge clk) wen |-> wmask != '0)
    else $error("data store enabled with empty byte mask");

endmodule

`default_nettype wire

/* rtl/rv_regfile.sv */
////////////////////
// integer register file, two async read ports and one write port
// x0 reads as zero, writes to it are dropped
////////////////////
`timescale 1ns/10ps
`default_nettype none

module rv_regfile #(
  parameter int AW = 5,
  parameter int DW = 64
) (
  input  wire logic          clk,
  input  wire logic          wen,
  input  wire logic [AW-1:0] rd,
  input  wire logic [DW-1:0] wdata,
  input  wire logic [AW-1:0] rs1,
  input  wire logic [AW-1:0] rs2,
  output logic [DW-1:0]      rdata_1,
  output logic [DW-1:0]      rdata_2
);

  logic [DW-1:0] regs [2**AW];

  // write port, x0 never stored
  always_ff @(posedge clk) begin
    if (wen && rd != '0)
      regs[rd] <= wdata;
  end

  // read ports, x0 forced to zero
  assign rdata_1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata_2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* rtl/rv_alu.sv */
////////////////////
// combinational alu, 64-bit ops plus the 32-bit word forms
// word mode masks shamt to 5 bits and sign extends bit 31
////////////////////
`timescale 1ns/10ps
`default_nettype none

module rv_alu (
  input  wire rv_pkg::xlen_t   a,
  input  wire rv_pkg::xlen_t   b,
  input  wire rv_pkg::alu_op_t op,
  input  wire logic            word,
  output rv_pkg::xlen_t        result
);

  logic [5:0]    shamt;
  rv_pkg::xlen_t sh_src;
  rv_pkg::xlen_t raw;

  always_comb begin
    shamt  = word ? {1'b0, b[4:0]} : b[5:0];
    // right shifts in word mode see only the low half of a
    sh_src = a;
    if (word)
      sh_src = (op == rv_pkg::alu_sra) ? {{32{a[31]}}, a[31:0]} : {32'b0, a[31:0]};
    case (op)
      rv_pkg::alu_add:    raw = a + b;
      rv_pkg::alu_sub:    raw = a - b;
      rv_pkg::alu_sll:    raw = a << shamt;
      rv_pkg::alu_slt:    raw = {63'b0, $signed(a) < $signed(b)};
      rv_pkg::alu_sltu:   raw = {63'b0, a < b};
      rv_pkg::alu_xor:    raw = a ^ b;
      rv_pkg::alu_srl:    raw = sh_src >> shamt;
      rv_pkg::alu_sra:    raw = $signed(sh_src) >>> shamt;
      rv_pkg::alu_or:     raw = a | b;
      rv_pkg::alu_and:    raw = a & b;
      rv_pkg::alu_pass_b: raw = b;
      default:            raw = '0;
    endcase
    result = word ? {{32{raw[31]}}, raw[31:0]} : raw;
  end

endmodule

`default_nettype wire

/* common/decode_if.sv */
////////////////////
// decoded control and operands, decoder to execute datapath
// dec side drives, exe side only reads
////////////////////
`timescale 1ns/10ps
`default_nettype none

interface decode_if;

  // register ids
  rv_pkg::reg_id_t   rd;
  rv_pkg::reg_id_t   rs1;
  rv_pkg::reg_id_t   rs2;
  // already sign extended for its format
  rv_pkg::xlen_t     imm;
  rv_pkg::alu_op_t   alu_op;
  logic              need_imm;
  // 32-bit op, result sign extended from bit 31
  logic              is_word;
  logic              is_auipc;
  logic              is_jal;
  logic              is_jalr;
  logic              is_load;
  logic              reg_wen;
  logic              mem_wen;
  rv_pkg::wmask_t    wmask;
  rv_pkg::mem_size_t mem_size;
  logic              load_unsigned;
  logic              is_ebreak;
  logic              is_illegal;

  modport dec (
    output rd, rs1, rs2, imm, alu_op, need_imm, is_word, is_auipc, is_jal, is_jalr,
    output is_load, reg_wen, mem_wen, wmask, mem_size, load_unsigned, is_ebreak, is_illegal
  );

  modport exe (
    input rd, rs1, rs2, imm, alu_op, need_imm, is_word, is_auipc, is_jal, is_jalr,
    input is_load, reg_wen, mem_wen, wmask, mem_size, load_unsigned, is_ebreak, is_illegal
  );

endinterface

`default_nettype wire

/* common/rv_pkg.sv */
////////////////////
// shared widths, opcodes and alu codes for the rv64i core
// referenced by scoped names from every rtl file
////////////////////
`default_nettype none

package rv_pkg;

  // data and address word
  typedef logic [63:0] xlen_t;
  // raw instruction
  typedef logic [31:0] inst_t;
  // register index, x0..x31
  typedef logic [4:0]  reg_id_t;
  typedef logic [3:0]  alu_op_t;
  // one enable bit per byte lane
  typedef logic [7:0]  wmask_t;
  // 0 byte, 1 half, 2 word, 3 double
  typedef logic [1:0]  mem_size_t;

  // alu codes follow {funct7[5], funct3} so op/op-imm decode is a direct copy
  localparam alu_op_t alu_add    = 4'b0000;
  localparam alu_op_t alu_sll    = 4'b0001;
  localparam alu_op_t alu_slt    = 4'b0010;
  localparam alu_op_t alu_sltu   = 4'b0011;
  localparam alu_op_t alu_xor    = 4'b0100;
  localparam alu_op_t alu_srl    = 4'b0101;
  localparam alu_op_t alu_or     = 4'b0110;
  localparam alu_op_t alu_and    = 4'b0111;
  localparam alu_op_t alu_sub    = 4'b1000;
  localparam alu_op_t alu_sra    = 4'b1101;
  // lui only, result is operand b
  localparam alu_op_t alu_pass_b = 4'b1111;

  // major opcodes, instr[6:0]
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_imm_32 = 7'b0011011;
  localparam logic [6:0] op        = 7'b0110011;
  localparam logic [6:0] op_32     = 7'b0111011;
  localparam logic [6:0] lui       = 7'b0110111;
  localparam logic [6:0] auipc     = 7'b0010111;
  localparam logic [6:0] jal       = 7'b1101111;
  localparam logic [6:0] jalr      = 7'b1100111;
  localparam logic [6:0] load      = 7'b0000011;
  localparam logic [6:0] store     = 7'b0100011;
  localparam logic [6:0] system    = 7'b1110011;

  // full ebreak encoding, every other system word is illegal here
  localparam inst_t ebreak_inst = 32'h0010_0073;

  // first fetch after reset
  localparam xlen_t reset_pc = 64'h8000_0000;

endpackage

`default_nettype wire
